/* project.f */
+incdir+hdl
hdl/fifoDataPkg.sv
hdl/fifoStatusPkg.sv
hdl/fifoRam.sv
hdl/fifoPointers.sv
hdl/fifoFlags.sv
hdl/syncFifo.sv
bench/fifoChecker.sv
bench/tbSyncFifo.sv

/* Bender.yml */
package:
  name: sync_fifo

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/fifoDataPkg.sv
      - hdl/fifoStatusPkg.sv
      - hdl/fifoRam.sv
      - hdl/fifoPointers.sv
      - hdl/fifoFlags.sv
      - hdl/syncFifo.sv
  - target: test
    files:
      - bench/fifoChecker.sv
      - bench/tbSyncFifo.sv

/* bench/tbSyncFifo.sv */
`timescale 1ns/10ps

module tbSyncFifo;

    // Stimulus kinds, one per table row
    typedef enum logic [2:0] {
        modeWrite,
        modeRead,
        modeWriteRead,
        modeClear,
        modeOverWrite,
        modeOverRead
    } modeT;

    // One row of the phase table
    typedef struct packed {
        logic [8*16-1:0] name;
        modeT            mode;
        logic [15:0]     cycles;
    } phaseT;

    localparam int numPhases   = 10;
    localparam int clkPeriod   = 100;
    localparam int resetCycles = 8;
    localparam int tailCycles  = 3;

    logic                 Clk;
    logic                 rstN;
    logic                 clr;
    logic                 we;
    logic                 re;
    fifoDataPkg::dataT    di;
    fifoDataPkg::dataT    dout;
    logic                 ack;
    logic                 ff;
    logic                 af;
    logic                 hf;
    logic                 ae;
    logic                 ef;
    fifoStatusPkg::countT cnt;

    logic [8*16-1:0] phaseName;
    phaseT           phases [0:numPhases-1];
    int              valueErrors;
    int              protocolErrors;
    int              checkCount;

    //////////////////////////////////////////////////
    // DUT and checker
    //////////////////////////////////////////////////

    syncFifo UUT (
        .Clk  (Clk),
        .rstN (rstN),
        .clr  (clr),
        .we   (we),
        .di   (di),
        .re   (re),
        .dout (dout),
        .ack  (ack),
        .ff   (ff),
        .af   (af),
        .hf   (hf),
        .ae   (ae),
        .ef   (ef),
        .cnt  (cnt)
    );

    // Watches the same nets as UUT
    fifoChecker uChecker (
        .Clk            (Clk),
        .rstN           (rstN),
        .clr            (clr),
        .we             (we),
        .di             (di),
        .re             (re),
        .dout           (dout),
        .ack            (ack),
        .ff             (ff),
        .af             (af),
        .hf             (hf),
        .ae             (ae),
        .ef             (ef),
        .cnt            (cnt),
        .phaseName      (phaseName),
        .valueErrors    (valueErrors),
        .protocolErrors (protocolErrors),
        .checkCount     (checkCount)
    );

    // 100 ns clock
    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    //////////////////////////////////////////////////
    // Phase table
    //////////////////////////////////////////////////

    task automatic setPhase(input int idx, input logic [8*16-1:0] name,
                            input modeT mode, input int cycles);
        phases[idx].name   = name;
        phases[idx].mode   = mode;
        phases[idx].cycles = cycles[15:0];
    endtask

    task automatic loadPhases();
        // Fill to 1024, then six dropped writes
        setPhase(0, "fill", modeWrite, 1024);
        setPhase(1, "overfill", modeOverWrite, 6);
        // Drain in order, then six dropped reads
        setPhase(2, "drain", modeRead, 1024);
        setPhase(3, "overdrain", modeOverRead, 6);
        // Half occupancy, then streaming at constant count
        setPhase(4, "halffill", modeWrite, 512);
        setPhase(5, "stream", modeWriteRead, 300);
        // Clear with 512 words held
        setPhase(6, "clear", modeClear, 1);
        // New word must come back, not a stale one
        setPhase(7, "afterclr", modeWrite, 1);
        setPhase(8, "readnew", modeRead, 1);
        setPhase(9, "readempty", modeOverRead, 2);
    endtask

    // Inputs for one cycle of a given mode
    task automatic driveInputs(input modeT mode);
        clr = 1'b0;
        we  = 1'b0;
        re  = 1'b0;
        di  = fifoDataPkg::dataT'($urandom);
        case (mode)
            modeWrite, modeOverWrite: we = 1'b1;
            modeRead, modeOverRead:   re = 1'b1;
            modeWriteRead: begin
                we = 1'b1;
                re = 1'b1;
            end
            modeClear: clr = 1'b1;
            default: clr = 1'b0;
        endcase
    endtask

    //////////////////////////////////////////////////
    // Stimulus loop
    //////////////////////////////////////////////////

    initial begin : stimulus
        int seed;
        seed      = 83759;
        loadPhases();
        rstN      = 1'b0;
        clr       = 1'b0;
        we        = 1'b0;
        re        = 1'b0;
        // Seeds the generator, first draw is the idle data
        di        = fifoDataPkg::dataT'($urandom(seed));
        phaseName = "reset";
        repeat (resetCycles) @(posedge Clk);
        #1;
        rstN = 1'b1;
        // Inputs change 1 ns after each rising edge
        for (int p = 0; p < numPhases; p++) begin
            for (int c = 0; c < phases[p].cycles; c++) begin
                @(posedge Clk);
                #1;
                phaseName = phases[p].name;
                driveInputs(phases[p].mode);
            end
        end
        // Idle tail lets the last ack reach the checker
        @(posedge Clk);
        #1;
        clr       = 1'b0;
        we        = 1'b0;
        re        = 1'b0;
        phaseName = "tail";
        repeat (tailCycles) @(posedge Clk);
        @(negedge Clk);
        #1;
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checkCount, valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0 && checkCount > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Limit is the table length plus 50 cycles
    initial begin : watchdog
        int limitCycles;
        @(posedge rstN);
        limitCycles = 50;
        for (int i = 0; i < numPhases; i++) begin
            limitCycles += phases[i].cycles;
        end
        #(limitCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("Verification failed");
        $finish;
    end

endmodule

/* bench/fifoChecker.sv */
`timescale 1ns/10ps

`include "fifo_macros.svh"

module fifoChecker (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  clr,
    input  logic                  we,
    input  fifoDataPkg::dataT     di,
    input  logic                  re,
    input  fifoDataPkg::dataT     dout,
    input  logic                  ack,
    input  logic                  ff,
    input  logic                  af,
    input  logic                  hf,
    input  logic                  ae,
    input  logic                  ef,
    input  fifoStatusPkg::countT  cnt,
    input  logic [8*16-1:0]       phaseName,
    output int                    valueErrors,
    output int                    protocolErrors,
    output int                    checkCount
);

    // Reference queue, front is the oldest word
    fifoDataPkg::dataT model [$];

    // Ack and word due after the coming edge
    logic              expAck;
    fifoDataPkg::dataT expData;

    // Phase that produced the outputs being compared
    logic [8*16-1:0] lastPhase;

    // Model occupancy before the coming edge
    int occ;

    initial begin
        valueErrors    = 0;
        protocolErrors = 0;
        checkCount     = 0;
        expAck         = 1'b0;
        expData        = '0;
        lastPhase      = '0;
    end

    // One value compare, reported on mismatch
    // Four-state so an unknown output counts as wrong
    task automatic compareField(input string fieldName, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            valueErrors++;
            $display("[FAIL] %0s: %0s expected %0d, actual %0d",
                     lastPhase, fieldName, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Compare and step, on the falling edge
    //////////////////////////////////////////////////

    // Outputs settled from the last rising edge
    // Inputs already driven for the next one
    always @(negedge Clk) begin
        if (!rstN) begin
            model.delete();
            expAck    = 1'b0;
            lastPhase = phaseName;
        end else begin
            occ = model.size();

            // Count and flag rules
            compareField("cnt", occ, cnt);
            compareField("ff", occ == `FIFO_DEPTH, ff);
            compareField("af", occ >= `FIFO_DEPTH - `FIFO_AF_MARGIN, af);
            compareField("hf", occ >= `FIFO_DEPTH / 2, hf);
            compareField("ae", occ <= `FIFO_AE_MARGIN, ae);
            compareField("ef", occ == 0, ef);

            // Ack pulse and read data
            checkCount++;
            if (ack !== expAck) begin
                protocolErrors++;
                if (expAck) begin
                    $display("Error in phase %0s: ack missing after an accepted read",
                             lastPhase);
                end else begin
                    $display("Error in phase %0s: ack raised with no accepted read",
                             lastPhase);
                end
            end else if (expAck) begin
                compareField("dout", expData, dout);
            end

            lastPhase = phaseName;

            // Acceptance for the coming edge, from model occupancy only
            expAck = 1'b0;
            if (clr) begin
                model.delete();
            end else begin
                // Pop before push, both judged on the old occupancy
                if (re && occ > 0) begin
                    expData = model.pop_front();
                    expAck  = 1'b1;
                end
                if (we && occ < `FIFO_DEPTH) begin
                    model.push_back(di);
                end
            end
        end
    end

endmodule

/* hdl/syncFifo.sv */
`timescale 1ns/10ps

module syncFifo (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  clr,
    input  logic                  we,
    input  fifoDataPkg::dataT     di,
    input  logic                  re,
    output fifoDataPkg::dataT     dout,
    output logic                  ack,
    output logic                  ff,
    output logic                  af,
    output logic                  hf,
    output logic                  ae,
    output logic                  ef,
    output fifoStatusPkg::countT  cnt
);

    // Internal buses
    fifoDataPkg::wrPortT   wrPort;
    fifoDataPkg::rdPortT   rdPort;
    fifoStatusPkg::countT  cntNext;
    fifoStatusPkg::flagsT  flags;

    //////////////////////////////////////////////////
    // Pointer control
    //////////////////////////////////////////////////

    // Full and empty fed back from the flag block
    fifoPointers uPointers (
        .Clk     (Clk),
        .rstN    (rstN),
        .clr     (clr),
        .we      (we),
        .di      (di),
        .re      (re),
        .flags   (flags),
        .wrPort  (wrPort),
        .rdPort  (rdPort),
        .cnt     (cnt),
        .cntNext (cntNext),
        .ack     (ack)
    );

    // Status flags from the next count
    fifoFlags uFlags (
        .Clk     (Clk),
        .rstN    (rstN),
        .cntNext (cntNext),
        .flags   (flags)
    );

    // Block RAM storage
    fifoRam uRam (
        .Clk    (Clk),
        .wrPort (wrPort),
        .rdPort (rdPort),
        .dout   (dout)
    );

    //////////////////////////////////////////////////
    // Flag outputs
    //////////////////////////////////////////////////

    assign ff = flags.full;
    assign af = flags.almostFull;
    assign hf = flags.halfFull;
    assign ae = flags.almostEmpty;
    assign ef = flags.empty;

endmodule

/* hdl/fifoFlags.sv */
`timescale 1ns/10ps

`include "fifo_macros.svh"

module fifoFlags (
    input  logic                  Clk,
    input  logic                  rstN,
    input  fifoStatusPkg::countT  cntNext,
    output fifoStatusPkg::flagsT  flags
);

    //////////////////////////////////////////////////
    // Thresholds
    //////////////////////////////////////////////////

    // All levels in count width
    localparam fifoStatusPkg::countT fullLevel =
        fifoStatusPkg::countT'(`FIFO_DEPTH);
    localparam fifoStatusPkg::countT afLevel =
        fifoStatusPkg::countT'(`FIFO_DEPTH - `FIFO_AF_MARGIN);
    localparam fifoStatusPkg::countT hfLevel =
        fifoStatusPkg::countT'(`FIFO_DEPTH / 2);
    localparam fifoStatusPkg::countT aeLevel =
        fifoStatusPkg::countT'(`FIFO_AE_MARGIN);

    // Flags for the count after this edge
    fifoStatusPkg::flagsT flagsNext;

    //////////////////////////////////////////////////
    // Compare next occupancy
    //////////////////////////////////////////////////

    always_comb begin
        flagsNext.full        = (cntNext == fullLevel);
        // At least depth minus margin
        flagsNext.almostFull  = (cntNext >= afLevel);
        flagsNext.halfFull    = (cntNext >= hfLevel);
        // At most the margin
        flagsNext.almostEmpty = (cntNext <= aeLevel);
        flagsNext.empty       = (cntNext == '0);
    end

    // Registered on the same edge as cnt
    // Reset gives the empty pattern
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            flags <= fifoStatusPkg::emptyFlags;
        end else begin
            flags <= flagsNext;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Full and empty exclude each other
    notFullAndEmpty: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(flags.full && flags.empty)
    ) else $error("fifoFlags: full and empty together");

    // Empty sits inside the almost empty band
    emptyImpliesAe: assert property (
        @(posedge Clk) disable iff (!rstN)
        flags.empty |-> flags.almostEmpty
    ) else $error("fifoFlags: empty without almost empty");

    // Full sits above both upper thresholds
    fullImpliesAfHf: assert property (
        @(posedge Clk) disable iff (!rstN)
        flags.full |-> (flags.almostFull && flags.halfFull)
    ) else $error("fifoFlags: full without almost full or half full");

endmodule

/* hdl/fifoPointers.sv */
`timescale 1ns/10ps

`include "fifo_macros.svh"

module fifoPointers (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  clr,
    input  logic                  we,
    input  fifoDataPkg::dataT     di,
    input  logic                  re,
    input  fifoStatusPkg::flagsT  flags,
    output fifoDataPkg::wrPortT   wrPort,
    output fifoDataPkg::rdPortT   rdPort,
    output fifoStatusPkg::countT  cnt,
    output fifoStatusPkg::countT  cntNext,
    output logic                  ack
);

    // Wrapping pointers into the RAM
    fifoDataPkg::addrT wrPtr;
    fifoDataPkg::addrT rdPtr;

    // Strobes that survive the full, empty and clr checks
    logic wrAccept;
    logic rdAccept;

    //////////////////////////////////////////////////
    // Strobe acceptance
    //////////////////////////////////////////////////

    // Full and empty come from the flag block
    // Registered from cntNext so they match cnt
    assign wrAccept = we && !flags.full && !clr;
    assign rdAccept = re && !flags.empty && !clr;

    // RAM ports
    always_comb begin
        wrPort.en   = wrAccept;
        wrPort.addr = wrPtr;
        wrPort.data = di;
    end

    always_comb begin
        rdPort.en   = rdAccept;
        rdPort.addr = rdPtr;
    end

    //////////////////////////////////////////////////
    // Next occupancy
    //////////////////////////////////////////////////

    // Clr wins over everything
    // Push and pop together leave the count alone
    always_comb begin
        if (clr) begin
            cntNext = '0;
        end else begin
            unique case ({wrAccept, rdAccept})
                2'b10:   cntNext = cnt + fifoStatusPkg::countT'(1);
                2'b01:   cntNext = cnt - fifoStatusPkg::countT'(1);
                default: cntNext = cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Pointer, count and ack registers
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else if (clr) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            // Pointers wrap at depth by width alone
            if (wrAccept) begin
                wrPtr <= wrPtr + fifoDataPkg::addrT'(1);
            end
            if (rdAccept) begin
                rdPtr <= rdPtr + fifoDataPkg::addrT'(1);
            end
        end
    end

    // Count updates on the accepting edge
    // Ack lines up with the registered RAM output
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '0;
            ack <= 1'b0;
        end else begin
            cnt <= cntNext;
            ack <= rdAccept;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A full count never moves the write pointer
    noWriteWhenFull: assert property (
        @(posedge Clk) disable iff (!rstN)
        (we && !clr && cnt == fifoStatusPkg::countT'(`FIFO_DEPTH)) |=> $stable(wrPtr)
    ) else $error("fifoPointers: write pointer moved while full");

    // Every ack comes with one step of the read pointer
    ackFromRead: assert property (
        @(posedge Clk) disable iff (!rstN)
        ack |-> (rdPtr == $past(rdPtr) + fifoDataPkg::addrT'(1))
    ) else $error("fifoPointers: ack without an accepted read");

endmodule

/* hdl/fifoRam.sv */
`timescale 1ns/10ps

`include "fifo_macros.svh"

module fifoRam (
    input  logic                 Clk,
    input  fifoDataPkg::wrPortT  wrPort,
    input  fifoDataPkg::rdPortT  rdPort,
    output fifoDataPkg::dataT    dout
);

    //////////////////////////////////////////////////
    // Storage array
    //////////////////////////////////////////////////

    // Depth by data width
    // Plain array with no reset so it maps onto block RAM
    fifoDataPkg::dataT mem [0:`FIFO_DEPTH-1];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Synchronous write
    // Address comes from the write pointer
    always_ff @(posedge Clk) begin
        if (wrPort.en) begin
            mem[wrPort.addr] <= wrPort.data;
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // Registered read output
    // Word appears one cycle after the accepted read
    // Holds the last word while no read is enabled
    always_ff @(posedge Clk) begin
        if (rdPort.en) begin
            dout <= mem[rdPort.addr];
        end
    end

    // Both ports never hit the same address in one cycle
    // Same address means empty or full, and one strobe is then refused
    // Read-during-write behaviour of the primitive does not matter

    // Write and read addresses differ whenever both ports fire
    ramPortsDistinct: assert property (
        @(posedge Clk)
        (wrPort.en && rdPort.en) |-> (wrPort.addr != rdPort.addr)
    ) else $error("fifoRam: write and read on the same address");

endmodule

/* hdl/fifoStatusPkg.sv */
`include "fifo_macros.svh"

package fifoStatusPkg;

    //////////////////////////////////////////////////
    // Occupancy and status types
    //////////////////////////////////////////////////

    // Word count 0..depth
    // One bit wider than the address to hold the full value
    typedef logic [`FIFO_ADDR_WIDTH:0] countT;

    // Status flags, MSB first
    typedef struct packed {
        logic full;
        logic almostFull;
        logic halfFull;
        logic almostEmpty;
        logic empty;
    } flagsT;

    // Flag pattern of an empty FIFO
    // Used at reset and after clr
    localparam flagsT emptyFlags = '{
        full:        1'b0,
        almostFull:  1'b0,
        halfFull:    1'b0,
        almostEmpty: 1'b1,
        empty:       1'b1
    };

endpackage

/* hdl/fifoDataPkg.sv */
`include "fifo_macros.svh"

package fifoDataPkg;

    //////////////////////////////////////////////////
    // Data path types
    //////////////////////////////////////////////////

    // One stored word
    typedef logic [`FIFO_DATA_WIDTH-1:0] dataT;

    // Block RAM address, wraps at depth
    typedef logic [`FIFO_ADDR_WIDTH-1:0] addrT;

    // RAM write port
    // Enable is already qualified by full and clr
    typedef struct packed {
        logic en;
        addrT addr;
        dataT data;
    } wrPortT;

    // RAM read port
    // Enable is already qualified by empty and clr
    typedef struct packed {
        logic en;
        addrT addr;
    } rdPortT;

endpackage

/* hdl/fifo_macros.svh */
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

//////////////////////////////////////////////////
// FIFO sizing
//////////////////////////////////////////////////

// Bits per stored word
`define FIFO_DATA_WIDTH 8

// RAM address bits
`define FIFO_ADDR_WIDTH 10

// Words of storage, 2 ** FIFO_ADDR_WIDTH
`define FIFO_DEPTH 1024

// Fixed flag thresholds
// Almost full within this many words of full
`define FIFO_AF_MARGIN 16
// Almost empty at or below this many words
`define FIFO_AE_MARGIN 16

`endif
